// ==== rtl/aes_pkg.sv ====
// aes_pkg: shared sizes, command codes and block mode type of the AES data-path controller

package aes_pkg;

	// bus word and block sizes
	localparam int WORD_S = 32;
	localparam int NB = 4;
	localparam int BLK_S = WORD_S * NB;

	// command word
	localparam int CMD_BITS = 32;

	// payload is a 128-bit key
	localparam logic [CMD_BITS-1:0] CMD_LOAD_KEY = 32'h1;
	// payload is XORed with the key
	localparam logic [CMD_BITS-1:0] CMD_MIX = 32'h2;

	// what the mixing stage does with a block
	typedef enum logic [1:0] {
		MODE_PASS = 2'd0,
		MODE_MIX = 2'd1,
		MODE_KEY = 2'd2
	} blk_mode_t;

	// fifo entry is {last, mode, block}
	localparam int MODE_BITS = 2;
	localparam int ENTRY_S = BLK_S + MODE_BITS + 1;

	// field positions inside an entry
	localparam int MODE_LSB = BLK_S;
	localparam int LAST_BIT = BLK_S + MODE_BITS;

endpackage

// ==== rtl/block_fifo.sv ====
// block_fifo: first-word-fall-through FIFO of tagged blocks with valid/ready on both sides

`timescale 1ns/1ps

module block_fifo #(
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        wvalid,
	output logic                        wready,
	input  logic [aes_pkg::ENTRY_S-1:0] wentry,

	output logic                        rvalid,
	input  logic                        rready,
	output logic [aes_pkg::ENTRY_S-1:0] rentry,

	output logic                        full
);

	localparam logic [FIFO_ADDR_WIDTH-1:0] LAST_SLOT = FIFO_ADDR_WIDTH'(FIFO_DEPTH - 1);
	localparam logic [FIFO_ADDR_WIDTH:0] DEPTH_COUNT = (FIFO_ADDR_WIDTH + 1)'(FIFO_DEPTH);

	logic [aes_pkg::ENTRY_S-1:0] mem [FIFO_DEPTH];
	logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
	logic [FIFO_ADDR_WIDTH:0] count;
	logic empty;
	logic do_write;
	logic do_read;

	assign full = (count == DEPTH_COUNT);
	assign empty = (count == '0);
	assign wready = ~full;
	assign rvalid = ~empty;

	assign do_write = wvalid & ~full;
	assign do_read = rready & ~empty;

	// head entry falls through to the read side
	assign rentry = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wentry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous read and write leaves the count alone
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== rtl/aes_controller_input.sv ====
// aes_controller_input: takes a command and payload words from the bus, packs tagged blocks

`timescale 1ns/1ps

module aes_controller_input (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        bus_data_wren,
	input  logic                        bus_tlast,
	input  logic [aes_pkg::WORD_S-1:0]  bus_data,

	output logic                        fifo_wvalid,
	input  logic                        fifo_wready,
	output logic [aes_pkg::ENTRY_S-1:0] fifo_wentry,
	input  logic                        fifo_full,
	input  logic                        fifo_empty,

	output logic                        controller_in_done,
	output logic                        controller_in_busy
);

	localparam logic GET_CMD = 1'b0;
	localparam logic GET_PAYLOAD = 1'b1;

	logic fsm_state;
	logic [aes_pkg::CMD_BITS-1:0] aes_cmd;
	aes_pkg::blk_mode_t cmd_mode;

	logic [1:0] word_cnt;
	logic [aes_pkg::BLK_S-1:0] aes_blk;
	logic [aes_pkg::BLK_S-1:0] aes_blk_next;
	logic block_available;

	// pending fifo entry
	logic [aes_pkg::BLK_S-1:0] entry_blk;
	aes_pkg::blk_mode_t entry_mode;
	logic entry_last;

	// new words enter at the top so the first word ends up in bits 31:0
	assign aes_blk_next = {bus_data, aes_blk[aes_pkg::BLK_S-1:aes_pkg::WORD_S]};
	assign block_available = bus_data_wren && (fsm_state == GET_PAYLOAD) &&
		(word_cnt == 2'(aes_pkg::NB - 1));

	always_comb begin
		case (aes_cmd)
			aes_pkg::CMD_LOAD_KEY: cmd_mode = aes_pkg::MODE_KEY;
			aes_pkg::CMD_MIX: cmd_mode = aes_pkg::MODE_MIX;
			default: cmd_mode = aes_pkg::MODE_PASS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fsm_state <= GET_CMD;
			aes_cmd <= '0;
			word_cnt <= '0;
		end else if (bus_data_wren) begin
			if (fsm_state == GET_CMD) begin
				aes_cmd <= bus_data;
				fsm_state <= GET_PAYLOAD;
			end else begin
				// counter wraps to zero after the fourth word
				word_cnt <= word_cnt + 1'b1;
				if (bus_tlast) begin
					fsm_state <= GET_CMD;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_data_wren && fsm_state == GET_PAYLOAD) begin
			aes_blk <= aes_blk_next;
		end
		if (block_available) begin
			entry_blk <= aes_blk_next;
			entry_mode <= cmd_mode;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fifo_wvalid <= 1'b0;
			entry_last <= 1'b0;
		end else if (block_available) begin
			fifo_wvalid <= 1'b1;
			entry_last <= bus_tlast;
		end else if (fifo_wvalid && fifo_wready) begin
			fifo_wvalid <= 1'b0;
		end
	end

	assign fifo_wentry = {entry_last, entry_mode, entry_blk};

	// done marks a fully queued packet until the fifo drains
	always_ff @(posedge clk) begin
		if (reset) begin
			controller_in_done <= 1'b0;
		end else if (fifo_wvalid && fifo_wready && entry_last) begin
			controller_in_done <= 1'b1;
		end else if (controller_in_done && fifo_empty) begin
			controller_in_done <= 1'b0;
		end
	end

	assign controller_in_busy = controller_in_done || fifo_full || fifo_wvalid;

endmodule

// ==== rtl/add_round_key.sv ====
// add_round_key: one-stage mixer that loads the key, XORs mix blocks and passes the rest

`timescale 1ns/1ps

module add_round_key (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic [aes_pkg::ENTRY_S-1:0] in_entry,

	output logic                        out_valid,
	input  logic                        out_ready,
	output logic [aes_pkg::BLK_S-1:0]   out_block,
	output logic                        out_last
);

	logic [aes_pkg::BLK_S-1:0] key;
	logic [aes_pkg::BLK_S-1:0] in_block;
	aes_pkg::blk_mode_t in_mode;
	logic accept;

	assign in_block = in_entry[aes_pkg::BLK_S-1:0];
	assign in_mode = aes_pkg::blk_mode_t'(in_entry[aes_pkg::MODE_LSB +: aes_pkg::MODE_BITS]);

	// the stage frees up in the same cycle its output leaves
	assign in_ready = ~out_valid | out_ready;
	assign accept = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			key <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (accept) begin
				if (in_mode == aes_pkg::MODE_KEY) begin
					key <= in_block;
				end else begin
					out_valid <= 1'b1;
					out_last <= in_entry[aes_pkg::LAST_BIT];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && in_mode != aes_pkg::MODE_KEY) begin
			out_block <= (in_mode == aes_pkg::MODE_MIX) ? (in_block ^ key) : in_block;
		end
	end

endmodule

// ==== rtl/aes_controller_output.sv ====
// aes_controller_output: splits 128-bit blocks into 32-bit words under valid/ready

`timescale 1ns/1ps

module aes_controller_output (
	input  logic                       clk,
	input  logic                       reset,

	input  logic                       blk_valid,
	output logic                       blk_ready,
	input  logic [aes_pkg::BLK_S-1:0]  blk_data,
	input  logic                       blk_last,

	output logic                       out_valid,
	input  logic                       out_ready,
	output logic [aes_pkg::WORD_S-1:0] out_data,
	output logic                       out_last
);

	localparam logic [1:0] LAST_WORD = 2'(aes_pkg::NB - 1);

	logic loaded;
	logic last_r;
	logic [1:0] word_idx;
	logic [aes_pkg::BLK_S-1:0] blk_r;
	logic word_xfer;

	// a new block is taken only when idle
	assign blk_ready = ~loaded;
	assign out_valid = loaded;
	assign word_xfer = loaded & out_ready;

	// word k sits in bits 32k+31:32k
	assign out_data = blk_r[word_idx * aes_pkg::WORD_S +: aes_pkg::WORD_S];
	assign out_last = loaded & last_r & (word_idx == LAST_WORD);

	always_ff @(posedge clk) begin
		if (reset) begin
			loaded <= 1'b0;
			last_r <= 1'b0;
			word_idx <= '0;
		end else if (!loaded) begin
			if (blk_valid) begin
				loaded <= 1'b1;
				last_r <= blk_last;
				word_idx <= '0;
			end
		end else if (word_xfer) begin
			if (word_idx == LAST_WORD) begin
				loaded <= 1'b0;
				word_idx <= '0;
			end else begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (blk_valid && blk_ready) begin
			blk_r <= blk_data;
		end
	end

endmodule

// ==== rtl/aes_controller.sv ====
// aes_controller: bus-independent AES data path of input packer, block FIFO, key mixer and output

`timescale 1ns/1ps

module aes_controller #(
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic                       clk,
	input  logic                       reset,

	input  logic                       bus_data_wren,
	input  logic                       bus_tlast,
	input  logic [aes_pkg::WORD_S-1:0] bus_data,

	output logic                       controller_in_done,
	output logic                       controller_in_busy,

	output logic                       out_valid,
	input  logic                       out_ready,
	output logic [aes_pkg::WORD_S-1:0] out_data,
	output logic                       out_last
);

	logic fifo_wvalid;
	logic fifo_wready;
	logic [aes_pkg::ENTRY_S-1:0] fifo_wentry;
	logic fifo_rvalid;
	logic fifo_rready;
	logic [aes_pkg::ENTRY_S-1:0] fifo_rentry;
	logic fifo_full;

	logic mix_valid;
	logic mix_ready;
	logic [aes_pkg::BLK_S-1:0] mix_block;
	logic mix_last;

	aes_controller_input input_i (
		.clk(clk),
		.reset(reset),
		.bus_data_wren(bus_data_wren),
		.bus_tlast(bus_tlast),
		.bus_data(bus_data),
		.fifo_wvalid(fifo_wvalid),
		.fifo_wready(fifo_wready),
		.fifo_wentry(fifo_wentry),
		.fifo_full(fifo_full),
		.fifo_empty(~fifo_rvalid),
		.controller_in_done(controller_in_done),
		.controller_in_busy(controller_in_busy)
	);

	block_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
	) fifo_i (
		.clk(clk),
		.reset(reset),
		.wvalid(fifo_wvalid),
		.wready(fifo_wready),
		.wentry(fifo_wentry),
		.rvalid(fifo_rvalid),
		.rready(fifo_rready),
		.rentry(fifo_rentry),
		.full(fifo_full)
	);

	add_round_key mix_i (
		.clk(clk),
		.reset(reset),
		.in_valid(fifo_rvalid),
		.in_ready(fifo_rready),
		.in_entry(fifo_rentry),
		.out_valid(mix_valid),
		.out_ready(mix_ready),
		.out_block(mix_block),
		.out_last(mix_last)
	);

	aes_controller_output output_i (
		.clk(clk),
		.reset(reset),
		.blk_valid(mix_valid),
		.blk_ready(mix_ready),
		.blk_data(mix_block),
		.blk_last(mix_last),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_last(out_last)
	);

endmodule

// ==== dv/aes_controller_checker.sv ====
// aes_controller_checker: bound assertions on the FIFO write, output hold and bus busy rules

`timescale 1ns/1ps

module aes_controller_checker (
	input logic                       clk,
	input logic                       reset,
	input logic                       bus_data_wren,
	input logic                       controller_in_busy,
	input logic                       controller_in_done,
	input logic                       fifo_wvalid,
	input logic                       fifo_wready,
	input logic                       out_valid,
	input logic                       out_ready,
	input logic [aes_pkg::WORD_S-1:0] out_data,
	input logic                       out_last
);

	int assert_failures = 0;

	// a finished packet drains before another block is queued
	no_write_while_done: assert property (@(posedge clk) disable iff (reset)
		!(fifo_wvalid && fifo_wready && controller_in_done))
	else begin
		$error("fifo write while controller_in_done is high");
		assert_failures++;
	end

	// a stalled word holds until it is taken
	out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
	else begin
		$error("output word changed while stalled");
		assert_failures++;
	end

	bus_respects_busy: assert property (@(posedge clk) disable iff (reset)
		!(bus_data_wren && controller_in_busy))
	else begin
		$error("bus write while controller_in_busy is high");
		assert_failures++;
	end

endmodule

bind aes_controller aes_controller_checker checker_i (.*);

// ==== dv/aes_controller_tb.sv ====
// aes_controller_tb: directed tests of the AES data-path controller against a word-level model

`timescale 1ns/1ps

module aes_controller_tb;

	// about 70 bus words at two cycles each plus drains, times four for random back-pressure
	localparam int CYCLE_LIMIT = 4000;
	localparam logic [31:0] CMD_KEY = 32'h1;
	localparam logic [31:0] CMD_XOR = 32'h2;
	localparam logic [31:0] CMD_OTHER = 32'h5;

	logic clk = 1'b0;
	logic reset;
	logic bus_data_wren;
	logic bus_tlast;
	logic [31:0] bus_data;
	logic out_ready = 1'b1;
	logic controller_in_done;
	logic controller_in_busy;
	logic out_valid;
	logic [31:0] out_data;
	logic out_last;

	integer seed = 32'hb2697cb7;
	logic [255:0] ready_pattern;
	logic random_ready = 1'b0;
	int cycles = 0;
	int busy_cycles = 0;
	int rx_count = 0;
	int word_errors = 0;
	int errors = 0;
	int failed_tests = 0;
	int test_start;
	logic [31:0] ref_key [4];
	logic [31:0] payload [$];
	logic [31:0] exp_data [$];
	logic exp_last [$];

	aes_controller #(
		.FIFO_DEPTH(4),
		.FIFO_ADDR_WIDTH(2)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.bus_data_wren(bus_data_wren),
		.bus_tlast(bus_tlast),
		.bus_data(bus_data),
		.controller_in_done(controller_in_done),
		.controller_in_busy(controller_in_busy),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_last(out_last)
	);

	always #20 clk = ~clk;

	// busy counter, output back-pressure, word collector and timeout
	always @(posedge clk) begin
		cycles++;
		if (controller_in_busy) busy_cycles++;
		out_ready <= random_ready ? ready_pattern[8'(cycles)] : 1'b1;
		if (!reset && out_valid && out_ready) begin
			if (rx_count >= exp_data.size()) begin
				$display("output word %h arrived when no word was expected", out_data);
				word_errors++;
			end else begin
				if (out_data !== exp_data[rx_count]) begin
					$display("CHECK FAILED out_data expected %h actual %h",
						exp_data[rx_count], out_data);
					word_errors++;
				end
				if (out_last !== exp_last[rx_count]) begin
					$display("CHECK FAILED out_last expected %h actual %h",
						exp_last[rx_count], out_last);
					word_errors++;
				end
			end
			rx_count++;
		end
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic int error_total();
		return errors + word_errors + dut_i.checker_i.assert_failures;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic fill_random(input int nblocks);
		payload.delete();
		for (int i = 0; i < 4 * nblocks; i++) begin
			payload.push_back($random(seed));
		end
	endtask

	// model first, then the command and payload go out on the bus
	task automatic run_packet(input logic [31:0] cmd);
		logic [31:0] word;
		for (int i = 0; i < payload.size(); i++) begin
			if (cmd == CMD_KEY) begin
				ref_key[2'(i)] = payload[i];
			end else begin
				exp_data.push_back((cmd == CMD_XOR) ? payload[i] ^ ref_key[2'(i)] : payload[i]);
				exp_last.push_back(i == payload.size() - 1);
			end
		end
		for (int i = 0; i <= payload.size(); i++) begin
			word = (i == 0) ? cmd : payload[i - 1];
			// busy seen low with the bus idle stays low through the next cycle
			@(negedge clk);
			while (controller_in_busy) @(negedge clk);
			@(posedge clk);
			bus_data_wren <= 1'b1;
			bus_data <= word;
			bus_tlast <= (i == payload.size());
			@(posedge clk);
			bus_data_wren <= 1'b0;
			bus_tlast <= 1'b0;
		end
	endtask

	task automatic drain();
		repeat (2) @(posedge clk);
		while (rx_count < exp_data.size() || controller_in_busy) @(posedge clk);
		// a stray word would still show up here
		repeat (8) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		if (error_total() == test_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, error_total() - test_start);
			failed_tests++;
		end
		test_start = error_total();
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		if (out_valid !== 1'b0) report_mismatch("out_valid", 32'h0, 32'(out_valid));
		if (out_last !== 1'b0) report_mismatch("out_last", 32'h0, 32'(out_last));
		if (controller_in_done !== 1'b0)
			report_mismatch("controller_in_done", 32'h0, 32'(controller_in_done));
		if (controller_in_busy !== 1'b0)
			report_mismatch("controller_in_busy", 32'h0, 32'(controller_in_busy));
	endtask

	task automatic test_backpressure();
		int busy_before;
		busy_before = busy_cycles;
		@(posedge clk);
		random_ready <= 1'b1;
		fill_random(6);
		run_packet(CMD_XOR);
		drain();
		random_ready <= 1'b0;
		if (busy_cycles == busy_before) begin
			$display("controller_in_busy never went high under back-pressure");
			errors++;
		end
	endtask

	task automatic test_done_level();
		fill_random(1);
		run_packet(CMD_OTHER);
		// the entry is written one edge after the fourth word, done follows one edge later
		repeat (2) @(negedge clk);
		if (controller_in_done !== 1'b1)
			report_mismatch("controller_in_done", 32'h1, 32'(controller_in_done));
		// the idle mixer empties the fifo on the next edge, done drops on the one after
		repeat (2) @(negedge clk);
		if (controller_in_done !== 1'b0)
			report_mismatch("controller_in_done", 32'h0, 32'(controller_in_done));
		drain();
		// a following packet goes through once done has dropped
		fill_random(1);
		run_packet(CMD_OTHER);
		drain();
	endtask

	initial begin
		reset = 1'b1;
		bus_data_wren = 1'b0;
		bus_tlast = 1'b0;
		bus_data = '0;
		ref_key = '{default: '0};
		for (int i = 0; i < 8; i++) begin
			ready_pattern = {ready_pattern[223:0], 32'($random(seed))};
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_start = error_total();
		test_reset_state();
		end_test("reset_state");
		fill_random(2);
		run_packet(CMD_OTHER);
		drain();
		end_test("pass_packet");
		fill_random(1);
		run_packet(CMD_KEY);
		fill_random(2);
		run_packet(CMD_XOR);
		drain();
		end_test("key_then_mix");
		fill_random(1);
		run_packet(CMD_KEY);
		fill_random(1);
		run_packet(CMD_XOR);
		fill_random(1);
		run_packet(CMD_OTHER);
		drain();
		end_test("key_replace");
		test_backpressure();
		end_test("backpressure");
		test_done_level();
		end_test("done_level");
		$display("tests run 6, tests failed %0d, errors %0d", failed_tests, error_total());
		if (error_total() == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
rtl/aes_pkg.sv
rtl/block_fifo.sv
rtl/aes_controller_input.sv
rtl/add_round_key.sv
rtl/aes_controller_output.sv
rtl/aes_controller.sv
dv/aes_controller_checker.sv
dv/aes_controller_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = aes_controller_tb
FILELIST = build.f
OBJ_DIR = obj_dir
PASS_MSG = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
